// File: verilog/noc_pkg.sv
// Shared types for the 2D mesh NoC router
// Port enumeration, flit format and one-hot output request

package noc_pkg;

  // ------------------------------------------------------------
  // Ports and sizes
  // ------------------------------------------------------------
  localparam int NUM_PORTS = 5;  // Local plus four compass ports
  localparam int COORD_W   = 4;  // Up to 16 nodes per axis
  localparam int PAYLOAD_W = 16;

  // Port numbers, also the index of every per-port array
  typedef enum logic [2:0] {
    PORT_C = 3'd0,  // Local core
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_S = 3'd3,
    PORT_W = 3'd4
  } port_e;

  // ------------------------------------------------------------
  // Flit format
  // ------------------------------------------------------------
  // Single-flit packets, destination travels with the payload
  typedef struct packed {
    logic [COORD_W-1:0]   dest_x;   // Destination column
    logic [COORD_W-1:0]   dest_y;   // Destination row
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // One-hot output request in [c,n,e,s,w] order
  // Ascending range puts c in the MSB and lets a port_e index the bit directly
  typedef logic [0:NUM_PORTS-1] port_req_t;

  localparam port_req_t REQ_NONE = 5'b00000;
  localparam port_req_t REQ_C    = 5'b10000;
  localparam port_req_t REQ_N    = 5'b01000;
  localparam port_req_t REQ_E    = 5'b00100;
  localparam port_req_t REQ_S    = 5'b00010;
  localparam port_req_t REQ_W    = 5'b00001;

endpackage

// File: verilog/noc_route_calc.sv
// Route calculator for one router input
// Oblivious dimension-ordered routing, X first then Y, local port on arrival

`timescale 1ns/1ps

module noc_route_calc
  import noc_pkg::*;
#(
  parameter int X_NODES = 4,  // Node columns in the mesh
  parameter int Y_NODES = 4,  // Node rows in the mesh
  parameter int X_LOC   = 0,  // Column of this router
  parameter int Y_LOC   = 0   // Row of this router
) (
  input  logic [COORD_W-1:0] i_dest_x,     // Destination column of the head flit
  input  logic [COORD_W-1:0] i_dest_y,     // Destination row of the head flit
  input  logic               i_val,        // Head flit present
  output port_req_t          o_output_req  // One-hot [c,n,e,s,w] request
);

  // ------------------------------------------------------------
  // Dimension-ordered routing
  // ------------------------------------------------------------
  always_comb begin
    o_output_req = REQ_NONE;  // No request without a flit
    if (i_val) begin
      if (i_dest_x != X_LOC) begin
        o_output_req = (i_dest_x > X_LOC) ? REQ_E : REQ_W;  // Correct X first
      end else if (i_dest_y != Y_LOC) begin
        o_output_req = (i_dest_y > Y_LOC) ? REQ_N : REQ_S;  // Then Y
      end else begin
        o_output_req = REQ_C;  // Arrived, eject locally
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // Upstream must never inject an address outside the mesh
  always_comb begin
    if (i_val) begin
      a_dest_in_mesh: assert final (i_dest_x < X_NODES && i_dest_y < Y_NODES)
        else $error("route_calc (%0d,%0d): dest (%0d,%0d) outside mesh",
                    X_LOC, Y_LOC, i_dest_x, i_dest_y);
    end
    a_req_onehot: assert final ($onehot0(o_output_req))
      else $error("route_calc (%0d,%0d): request %b not one-hot", X_LOC, Y_LOC, o_output_req);
    // Edge routers have no neighbour beyond the boundary
    a_req_on_mesh: assert final (
        !(o_output_req[PORT_E] && X_LOC >= X_NODES - 1) &&
        !(o_output_req[PORT_W] && X_LOC == 0) &&
        !(o_output_req[PORT_N] && Y_LOC >= Y_NODES - 1) &&
        !(o_output_req[PORT_S] && Y_LOC == 0))
      else $error("route_calc (%0d,%0d): request %b leaves the mesh", X_LOC, Y_LOC, o_output_req);
  end

endmodule

// File: verilog/noc_input_fifo.sv
// Input FIFO for one router port
// Circular buffer feeding a registered head stage, full level for upstream

`timescale 1ns/1ps

module noc_input_fifo
  import noc_pkg::*;
#(
  parameter int FIFO_DEPTH = 4  // Flits stored before o_full rises
) (
  input  logic  clk,
  input  logic  i_rst_n,
  input  logic  i_wr,         // Write strobe from upstream
  input  flit_t i_wr_flit,
  input  logic  i_pop,        // Head consumed by the crossbar this cycle
  output flit_t o_head_flit,
  output logic  o_head_val,
  output logic  o_full        // Upstream must hold off while high
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  flit_t            mem [FIFO_DEPTH];  // Entries behind the head
  logic [PTR_W-1:0] rd_ptr, wr_ptr;
  logic [CNT_W-1:0] buf_cnt;           // Entries in mem, head not counted
  logic             head_load;         // Move oldest entry into the head

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;  // Wrap at depth
  endfunction

  // Head refills when empty or popped, so one flit per cycle drains
  assign head_load = (buf_cnt != '0) && (!o_head_val || i_pop);
  assign o_full    = (buf_cnt + CNT_W'(o_head_val)) >= CNT_W'(FIFO_DEPTH);

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      buf_cnt    <= '0;
      o_head_val <= 1'b0;
    end else begin
      if (i_wr)      wr_ptr <= ptr_inc(wr_ptr);
      if (head_load) rd_ptr <= ptr_inc(rd_ptr);
      buf_cnt <= buf_cnt + CNT_W'(i_wr) - CNT_W'(head_load);
      if (head_load)  o_head_val <= 1'b1;
      else if (i_pop) o_head_val <= 1'b0;  // Popped with nothing behind it
    end
  end

  // Storage and head payload
  always_ff @(posedge clk) begin
    if (i_wr)      mem[wr_ptr] <= i_wr_flit;
    if (head_load) o_head_flit <= mem[rd_ptr];
  end

  // ------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------
  a_no_wr_full: assert property (@(posedge clk) disable iff (!i_rst_n) i_wr |-> !o_full)
    else $error("input_fifo: write while full");
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_rst_n) i_pop |-> o_head_val)
    else $error("input_fifo: pop with empty head");

endmodule

// File: verilog/noc_switch_alloc.sv
// Switch allocator with one round-robin arbiter per output
// Turns route requests into crossbar grants and FIFO pops

`timescale 1ns/1ps

module noc_switch_alloc
  import noc_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  port_req_t            i_req       [NUM_PORTS],  // Indexed by input
  output logic [NUM_PORTS-1:0] o_pop,                    // Indexed by input
  output port_e                o_grant_idx [NUM_PORTS],  // Winning input per output
  output logic [NUM_PORTS-1:0] o_grant_val               // Indexed by output
);

  logic [NUM_PORTS-1:0] gnt_mtx [NUM_PORTS];  // [input][output] grant matrix

  // ------------------------------------------------------------
  // Per-output arbiters
  // ------------------------------------------------------------
  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_arb
    port_e ptr;      // Highest priority input this cycle
    port_e win;
    logic  win_val;

    // Search inputs from ptr in port order, first requester wins
    always_comb begin
      int idx;
      win     = PORT_C;
      win_val = 1'b0;
      for (int k = 0; k < NUM_PORTS; k++) begin
        idx = int'(ptr) + k;
        if (idx >= NUM_PORTS) idx = idx - NUM_PORTS;  // Wrap around
        if (!win_val && i_req[idx][o]) begin
          win     = port_e'(idx);
          win_val = 1'b1;
        end
      end
    end

    // Pointer moves one past the winner, holds when idle
    always_ff @(posedge clk) begin
      if (!i_rst_n) begin
        ptr <= PORT_C;
      end else if (win_val) begin
        ptr <= (int'(win) == NUM_PORTS - 1) ? PORT_C : port_e'(int'(win) + 1);
      end
    end

    assign o_grant_idx[o] = win;
    assign o_grant_val[o] = win_val;
  end

  // ------------------------------------------------------------
  // Pops back to the input FIFOs
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        gnt_mtx[i][o] = o_grant_val[o] && (o_grant_idx[o] == port_e'(i));
      end
      o_pop[i] = |gnt_mtx[i];  // At most one grant since one output is requested
    end
  end

  // An input holding one flit can only leave through one output
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chk
    a_single_grant: assert property (@(posedge clk) disable iff (!i_rst_n)
        $onehot0(gnt_mtx[i]))
      else $error("switch_alloc: input %0d granted by several outputs", i);
  end

endmodule

// File: verilog/noc_crossbar.sv
// Registered five-by-five flit crossbar
// Each output takes the head flit of the input its arbiter granted

`timescale 1ns/1ps

module noc_crossbar
  import noc_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  flit_t                i_in_flit   [NUM_PORTS],  // FIFO heads, by input
  input  port_e                i_grant_idx [NUM_PORTS],  // Selected input, by output
  input  logic [NUM_PORTS-1:0] i_grant_val,              // By output
  output flit_t                o_out_flit  [NUM_PORTS],
  output logic [NUM_PORTS-1:0] o_out_valid               // One-cycle strobes
);

  flit_t sel_flit [NUM_PORTS];  // Mux outputs ahead of the register

  // ------------------------------------------------------------
  // Selection
  // ------------------------------------------------------------
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      sel_flit[o] = i_in_flit[i_grant_idx[o]];
    end
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  // Strobes only, neighbour always accepts
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_out_valid <= '0;
    end else begin
      o_out_valid <= i_grant_val;
    end
  end

  // Payload loads only on a grant, holds otherwise
  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (i_grant_val[o]) o_out_flit[o] <= sel_flit[o];
    end
  end

endmodule

// File: verilog/noc_router.sv
// Mesh NoC router top level
// Five input FIFOs, route calculators, switch allocator and registered crossbar

`timescale 1ns/1ps

module noc_router
  import noc_pkg::*;
#(
  parameter int X_NODES    = 4,  // Mesh columns
  parameter int Y_NODES    = 4,  // Mesh rows
  parameter int X_LOC      = 0,  // This router's column
  parameter int Y_LOC      = 0,  // This router's row
  parameter int FIFO_DEPTH = 4   // Input buffering per port
) (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  flit_t                i_in_flit  [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] i_in_valid,   // Write strobes, by port
  output logic [NUM_PORTS-1:0] o_in_full,    // Back-pressure, by port
  output flit_t                o_out_flit [NUM_PORTS],
  output logic [NUM_PORTS-1:0] o_out_valid   // Strobes, always accepted
);

  flit_t                head_flit [NUM_PORTS];  // FIFO heads
  logic [NUM_PORTS-1:0] head_val;
  logic [NUM_PORTS-1:0] pop;                    // From allocator, by input
  port_req_t            req       [NUM_PORTS];  // Route requests, by input
  port_e                grant_idx [NUM_PORTS];  // By output
  logic [NUM_PORTS-1:0] grant_val;

  // ------------------------------------------------------------
  // Input side, one FIFO and route calculator per port
  // ------------------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
    noc_input_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_wr        (i_in_valid[p]),
      .i_wr_flit   (i_in_flit[p]),
      .i_pop       (pop[p]),
      .o_head_flit (head_flit[p]),
      .o_head_val  (head_val[p]),
      .o_full      (o_in_full[p])
    );

    noc_route_calc #(
      .X_NODES (X_NODES),
      .Y_NODES (Y_NODES),
      .X_LOC   (X_LOC),
      .Y_LOC   (Y_LOC)
    ) u_route (
      .i_dest_x     (head_flit[p].dest_x),
      .i_dest_y     (head_flit[p].dest_y),
      .i_val        (head_val[p]),
      .o_output_req (req[p])
    );
  end

  // ------------------------------------------------------------
  // Allocation and switching
  // ------------------------------------------------------------
  noc_switch_alloc u_alloc (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req       (req),
    .o_pop       (pop),
    .o_grant_idx (grant_idx),
    .o_grant_val (grant_val)
  );

  noc_crossbar u_xbar (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_in_flit   (head_flit),
    .i_grant_idx (grant_idx),
    .i_grant_val (grant_val),
    .o_out_flit  (o_out_flit),
    .o_out_valid (o_out_valid)
  );

endmodule

// File: verif/noc_router_tb.sv
// Testbench for the mesh NoC router at node (1,2) of a 4x4 mesh
// Random single-flit traffic checked against a per-output, per-source queue model

`timescale 1ns/1ps

module noc_router_tb
  import noc_pkg::*;
();

  localparam int X_NODES = 4;
  localparam int Y_NODES = 4;
  localparam int X_LOC   = 1;
  localparam int Y_LOC   = 2;

  logic                 clk;
  logic                 i_rst_n;
  flit_t                i_in_flit  [NUM_PORTS];
  logic [NUM_PORTS-1:0] i_in_valid;
  logic [NUM_PORTS-1:0] o_in_full;
  flit_t                o_out_flit [NUM_PORTS];
  logic [NUM_PORTS-1:0] o_out_valid;

  integer      seed;
  int          err_cnt, pass_cnt, fail_cnt;
  logic [12:0] seq [NUM_PORTS];                   // Next sequence number per source
  flit_t       exp_q [NUM_PORTS][NUM_PORTS][$];   // [output][source] expected flits

  noc_router #(
    .X_NODES (X_NODES), .Y_NODES (Y_NODES), .X_LOC (X_LOC), .Y_LOC (Y_LOC), .FIFO_DEPTH (4)
  ) uut (
    .clk (clk), .i_rst_n (i_rst_n), .i_in_flit (i_in_flit), .i_in_valid (i_in_valid),
    .o_in_full (o_in_full), .o_out_flit (o_out_flit), .o_out_valid (o_out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  // X first, then Y, local port once both match
  function automatic int route_port(input logic [COORD_W-1:0] dx, input logic [COORD_W-1:0] dy);
    if (dx != X_LOC) return (dx > X_LOC) ? int'(PORT_E) : int'(PORT_W);
    if (dy != Y_LOC) return (dy > Y_LOC) ? int'(PORT_N) : int'(PORT_S);
    return int'(PORT_C);
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int o = 0; o < NUM_PORTS; o++)
      for (int s = 0; s < NUM_PORTS; s++) n += exp_q[o][s].size();
    return n;
  endfunction

  // Drive one flit on port p and log it in the model
  task automatic send_flit(input int p, input logic [COORD_W-1:0] dx,
                           input logic [COORD_W-1:0] dy);
    flit_t f;
    f.dest_x      = dx;
    f.dest_y      = dy;
    f.payload     = {3'(p), seq[p]};  // Source in top 3 bits
    i_in_flit[p]  = f;
    i_in_valid[p] = 1'b1;
    exp_q[route_port(dx, dy)][p].push_back(f);
    seq[p]++;
  endtask

  task automatic apply_reset();
    i_rst_n    = 1'b0;
    i_in_valid = '0;
    for (int o = 0; o < NUM_PORTS; o++)
      for (int s = 0; s < NUM_PORTS; s++) exp_q[o][s].delete();
    repeat (10) @(negedge clk);
    i_rst_n = 1'b1;
  endtask

  // Idle inputs until the model has seen every flit come out
  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (outstanding() != 0 && n < limit) begin
      @(negedge clk);
      i_in_valid = '0;
      n++;
    end
    assert (outstanding() == 0) else begin
      $display("ERROR: %0d flits still missing after %0d cycles", outstanding(), limit);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    if (err_cnt == start_err) begin
      pass_cnt++;
      $display("test %-9s ok", name);
    end else begin
      fail_cnt++;
      $display("test %-9s fail (%0d errors)", name, err_cnt - start_err);
    end
  endtask

  // ------------------------------------------------------------
  // Output monitor
  // ------------------------------------------------------------
  always @(negedge clk) begin : out_monitor
    flit_t got;
    flit_t exp_f;
    int    src;
    if (i_rst_n) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (o_out_valid[p]) begin
          got = o_out_flit[p];
          src = int'(got.payload[PAYLOAD_W-1 -: 3]);
          assert (src < NUM_PORTS && exp_q[p][src].size() > 0) else begin
            $display("ERROR: unexpected flit %h on output %0d", got, p);
            err_cnt++;
          end
          if (src < NUM_PORTS && exp_q[p][src].size() > 0) begin
            exp_f = exp_q[p][src].pop_front();  // Oldest flit from this source
            assert (got == exp_f) else begin
              $display("MISMATCH o_out_flit[%0d] got %h exp %h", p, got, exp_f);
              err_cnt++;
            end
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin : main
    int   start_err, r, lat, next_src, src;
    logic seen, started, saw_full;
    seed    = 32'h59ca309f;
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    i_rst_n    = 1'b0;
    i_in_valid = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      i_in_flit[p] = '0;
      seq[p]       = '0;
    end
    apply_reset();

    start_err = err_cnt;  // Quiet after reset
    repeat (10) begin
      @(negedge clk);
      assert (o_out_valid == '0) else begin
        $display("MISMATCH o_out_valid got %h exp %h", o_out_valid, 5'h00);
        err_cnt++;
      end
      assert (o_in_full == '0) else begin
        $display("MISMATCH o_in_full got %h exp %h", o_in_full, 5'h00);
        err_cnt++;
      end
    end
    report_test("reset", start_err);

    start_err = err_cnt;  // One flit at a time, random port and destination
    for (int n = 0; n < 20; n++) begin
      @(negedge clk);
      r = $random(seed);
      send_flit(int'(r[7:0]) % NUM_PORTS, r[9:8], r[11:10]);
      @(negedge clk);
      i_in_valid = '0;
      wait_drain(20);
    end
    report_test("routing", start_err);

    start_err = err_cnt;  // Lone flit latency
    for (int n = 0; n < 5; n++) begin
      @(negedge clk);
      r = $random(seed);
      send_flit(int'(r[7:0]) % NUM_PORTS, r[9:8], r[11:10]);
      lat  = 0;
      seen = 1'b0;
      while (!seen && lat < 10) begin
        @(negedge clk);
        i_in_valid = '0;
        lat++;
        seen = (o_out_valid != '0);
      end
      assert (seen) else begin
        $display("ERROR: lone flit never reached an output");
        err_cnt++;
      end
      if (seen) begin
        assert (lat - 1 == 2) else begin  // Edges counted after the accepting edge
          $display("MISMATCH latency got %h exp %h", lat - 1, 2);
          err_cnt++;
        end
      end
      wait_drain(10);
    end
    report_test("latency", start_err);

    start_err = err_cnt;  // Random load on every port
    for (int cyc = 0; cyc < 200; cyc++) begin
      @(negedge clk);
      i_in_valid = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        r = $random(seed);
        if (r[0] && !o_in_full[p]) send_flit(p, r[5:4], r[7:6]);
      end
    end
    @(negedge clk);
    i_in_valid = '0;
    wait_drain(200);
    repeat (5) @(negedge clk);  // Room for any stray flit
    report_test("order", start_err);

    start_err = err_cnt;  // Every input streams to the local port
    apply_reset();        // Arbiter pointers back at c
    next_src = 0;
    started  = 1'b0;
    saw_full = 1'b0;
    for (int cyc = 0; cyc < 60; cyc++) begin
      @(negedge clk);
      i_in_valid = '0;
      if (o_out_valid[PORT_C]) begin
        src = int'(o_out_flit[PORT_C].payload[PAYLOAD_W-1 -: 3]);
        assert (src == next_src) else begin
          $display("MISMATCH o_out_flit[0] source got %h exp %h", src, next_src);
          err_cnt++;
        end
        next_src = (next_src + 1) % NUM_PORTS;  // Round robin from c
        started  = 1'b1;
      end else begin
        assert (!started) else begin
          $display("ERROR: local output idle while all inputs hold flits");
          err_cnt++;
        end
      end
      if (o_in_full != '0) saw_full = 1'b1;
      for (int p = 0; p < NUM_PORTS; p++)
        if (!o_in_full[p]) send_flit(p, X_LOC, Y_LOC);  // Never write a full FIFO
    end
    assert (started && saw_full) else begin
      $display("ERROR: stream never filled an input FIFO or reached the local output");
      err_cnt++;
    end
    @(negedge clk);
    i_in_valid = '0;
    wait_drain(100);
    report_test("fairness", start_err);

    $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: noc_router.f
verilog/noc_pkg.sv
verilog/noc_route_calc.sv
verilog/noc_input_fifo.sv
verilog/noc_switch_alloc.sv
verilog/noc_crossbar.sv
verilog/noc_router.sv
verif/noc_router_tb.sv
